// ==== hw/dvi_sync_macros.svh ====
// DVI sync widths and chip timing
`ifndef DVI_SYNC_MACROS_SVH
`define DVI_SYNC_MACROS_SVH

// --------------------
// widths
`define H_W     11 // output column, doubled
`define V_W     10 // output line, doubled
`define RX_W    10 // native raster column
`define RY_W    9  // native raster line
`define COLOR_W 4  // palette index
`define CHIP_W  2

// chip codes as seen on the chip select pins
`define CHIP_6567R8   0
`define CHIP_6569R3   1
`define CHIP_6567R56A 2
`define CHIP_6569R1   3

// --------------------
// 6567R8, 520 native columns, 263 lines
`define HS_STA_NTSC8   6
`define HS_END_NTSC8   38
`define HA_STA_NTSC8   44
`define HA_END_NTSC8   510
`define VS_STA_NTSC8   14
`define VS_END_NTSC8   22
`define VA_STA_NTSC8   23
`define VA_END_NTSC8   13
`define MAX_W_NTSC8    844 // already doubled
`define MAX_H_NTSC8    525
`define X_OFFSET_NTSC8 130

// 6567R56A, 512 native columns, 262 lines
`define HS_STA_NTSC56   6
`define HS_END_NTSC56   38
`define HA_STA_NTSC56   44
`define HA_END_NTSC56   502
`define VS_STA_NTSC56   14
`define VS_END_NTSC56   22
`define VA_STA_NTSC56   23
`define VA_END_NTSC56   13
`define MAX_W_NTSC56    831
`define MAX_H_NTSC56    523
`define X_OFFSET_NTSC56 130

// 6569 both revisions, 504 native columns, 312 lines
`define HS_STA_PAL   0
`define HS_END_PAL   64
`define HA_STA_PAL   80
`define HA_END_PAL   494
`define VS_STA_PAL   301
`define VS_END_PAL   309
`define VA_STA_PAL   310
`define VA_END_PAL   300
`define MAX_W_PAL    944
`define MAX_H_PAL    623
`define X_OFFSET_PAL 40

`endif

// ==== hw/dvi_sync_pkg.sv ====
// DVI sync shared types
`include "dvi_sync_macros.svh"

package dvi_sync_pkg;

    // --------------------
    // output raster position, both axes doubled
    typedef logic [`H_W-1:0] hcount_t;   // x on the DVI side
    typedef logic [`V_W-1:0] vcount_t;   // y on the DVI side

    // native source position
    typedef logic [`RX_W-1:0] raster_x_t; // also the line buffer address
    typedef logic [`RY_W-1:0] raster_y_t;

    // pixel payload
    typedef logic [`COLOR_W-1:0] color_t; // palette index, not rgb

    // chip select, see CHIP_* codes
    typedef logic [`CHIP_W-1:0] chip_t;

endpackage

// ==== hw/chip_timing.sv ====
// Per-chip DVI timing set
`timescale 1ns/10ps
`include "dvi_sync_macros.svh"

module chip_timing (
    input  logic                  clk_dvi,
    input  logic                  rst,
    input  dvi_sync_pkg::chip_t   chip,
    output dvi_sync_pkg::hcount_t hs_sta,
    output dvi_sync_pkg::hcount_t hs_end,
    output dvi_sync_pkg::hcount_t ha_sta,
    output dvi_sync_pkg::hcount_t ha_end,
    output dvi_sync_pkg::hcount_t max_width,
    output dvi_sync_pkg::hcount_t x_offset,
    output dvi_sync_pkg::vcount_t vs_sta,
    output dvi_sync_pkg::vcount_t vs_end,
    output dvi_sync_pkg::vcount_t va_sta,
    output dvi_sync_pkg::vcount_t va_end,
    output dvi_sync_pkg::vcount_t max_height
);

    // undoubled table entry
    dvi_sync_pkg::hcount_t t_hs_sta, t_hs_end, t_ha_sta, t_ha_end, t_max_w, t_x_off;
    dvi_sync_pkg::vcount_t t_vs_sta, t_vs_end, t_va_sta, t_va_end, t_max_h;

    // --------------------
    // table lookup
    always_comb begin
        case (chip)
            `CHIP_6567R8: begin
                t_hs_sta = dvi_sync_pkg::hcount_t'(`HS_STA_NTSC8);
                t_hs_end = dvi_sync_pkg::hcount_t'(`HS_END_NTSC8);
                t_ha_sta = dvi_sync_pkg::hcount_t'(`HA_STA_NTSC8);
                t_ha_end = dvi_sync_pkg::hcount_t'(`HA_END_NTSC8);
                t_max_w  = dvi_sync_pkg::hcount_t'(`MAX_W_NTSC8);
                t_x_off  = dvi_sync_pkg::hcount_t'(`X_OFFSET_NTSC8);
                t_vs_sta = dvi_sync_pkg::vcount_t'(`VS_STA_NTSC8);
                t_vs_end = dvi_sync_pkg::vcount_t'(`VS_END_NTSC8);
                t_va_sta = dvi_sync_pkg::vcount_t'(`VA_STA_NTSC8);
                t_va_end = dvi_sync_pkg::vcount_t'(`VA_END_NTSC8);
                t_max_h  = dvi_sync_pkg::vcount_t'(`MAX_H_NTSC8);
            end
            `CHIP_6567R56A: begin
                t_hs_sta = dvi_sync_pkg::hcount_t'(`HS_STA_NTSC56);
                t_hs_end = dvi_sync_pkg::hcount_t'(`HS_END_NTSC56);
                t_ha_sta = dvi_sync_pkg::hcount_t'(`HA_STA_NTSC56);
                t_ha_end = dvi_sync_pkg::hcount_t'(`HA_END_NTSC56);
                t_max_w  = dvi_sync_pkg::hcount_t'(`MAX_W_NTSC56);
                t_x_off  = dvi_sync_pkg::hcount_t'(`X_OFFSET_NTSC56);
                t_vs_sta = dvi_sync_pkg::vcount_t'(`VS_STA_NTSC56);
                t_vs_end = dvi_sync_pkg::vcount_t'(`VS_END_NTSC56);
                t_va_sta = dvi_sync_pkg::vcount_t'(`VA_STA_NTSC56);
                t_va_end = dvi_sync_pkg::vcount_t'(`VA_END_NTSC56);
                t_max_h  = dvi_sync_pkg::vcount_t'(`MAX_H_NTSC56);
            end
            default: begin // 6569R1 and 6569R3 share the PAL set
                t_hs_sta = dvi_sync_pkg::hcount_t'(`HS_STA_PAL);
                t_hs_end = dvi_sync_pkg::hcount_t'(`HS_END_PAL);
                t_ha_sta = dvi_sync_pkg::hcount_t'(`HA_STA_PAL);
                t_ha_end = dvi_sync_pkg::hcount_t'(`HA_END_PAL);
                t_max_w  = dvi_sync_pkg::hcount_t'(`MAX_W_PAL);
                t_x_off  = dvi_sync_pkg::hcount_t'(`X_OFFSET_PAL);
                t_vs_sta = dvi_sync_pkg::vcount_t'(`VS_STA_PAL);
                t_vs_end = dvi_sync_pkg::vcount_t'(`VS_END_PAL);
                t_va_sta = dvi_sync_pkg::vcount_t'(`VA_STA_PAL);
                t_va_end = dvi_sync_pkg::vcount_t'(`VA_END_PAL);
                t_max_h  = dvi_sync_pkg::vcount_t'(`MAX_H_PAL);
            end
        endcase
    end

    // --------------------
    // capture while held in reset, frozen afterwards
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hs_sta     <= t_hs_sta << 1; // x is always doubled
            hs_end     <= t_hs_end << 1;
            ha_sta     <= t_ha_sta << 1;
            ha_end     <= t_ha_end << 1;
            vs_sta     <= t_vs_sta << 1; // y too, no native line mode
            vs_end     <= t_vs_end << 1;
            va_sta     <= t_va_sta << 1;
            va_end     <= t_va_end << 1;
            max_width  <= t_max_w;       // limits come pre-doubled
            max_height <= t_max_h;
            x_offset   <= t_x_off;
        end
    end

endmodule

// ==== hw/raster_counter.sv ====
// Output raster counters
`timescale 1ns/10ps

module raster_counter (
    input  logic                  clk_dvi,
    input  logic                  rst,
    input  dvi_sync_pkg::hcount_t max_width,  // last column
    input  dvi_sync_pkg::vcount_t max_height, // last line
    output dvi_sync_pkg::hcount_t h_count,
    output dvi_sync_pkg::vcount_t v_count
);

    logic line_last;  // on the final column
    logic frame_last; // on the final line

    assign line_last  = !(h_count < max_width);
    assign frame_last = !(v_count < max_height);

    // --------------------
    // one output pixel per clock, every line counts since y is doubled
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_last) begin
            h_count <= '0;
            if (frame_last)
                v_count <= '0; // frame wrap
            else
                v_count <= v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

endmodule

// ==== hw/sync_decoder.sv ====
// DVI sync and active decoder
`timescale 1ns/10ps

module sync_decoder (
    input  logic                  clk_dvi,
    input  logic                  rst,
    input  logic                  hpolarity,  // 1 = active high
    input  logic                  vpolarity,
    input  dvi_sync_pkg::hcount_t h_count,
    input  dvi_sync_pkg::vcount_t v_count,
    input  dvi_sync_pkg::hcount_t hs_sta,
    input  dvi_sync_pkg::hcount_t hs_end,
    input  dvi_sync_pkg::hcount_t ha_sta,
    input  dvi_sync_pkg::hcount_t ha_end,
    input  dvi_sync_pkg::hcount_t max_width,
    input  dvi_sync_pkg::vcount_t vs_sta,
    input  dvi_sync_pkg::vcount_t vs_end,
    input  dvi_sync_pkg::vcount_t va_sta,
    input  dvi_sync_pkg::vcount_t va_end,
    input  dvi_sync_pkg::vcount_t max_height,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active,
    output logic                  half_bright
);

    logic hsync_ah, vsync_ah; // before polarity
    logic in_hwin;            // between left and right border
    logic in_vblank;          // inside the vertical blank window
    logic line_end, frame_end;
    logic line_odd;           // parity of the line the counters sit on

    // --------------------
    // window compares, raster order for the vertical ones
    assign hsync_ah = (h_count >= hs_sta) && (h_count < hs_end);
    // vsync starts at (vs_sta, hs_sta) and stops at (vs_end, hs_end)
    assign vsync_ah = ((v_count == vs_sta && h_count >= hs_sta) || v_count > vs_sta) &&
                      ((v_count == vs_end && h_count < hs_end) || v_count < vs_end);
    assign in_hwin   = (h_count > ha_sta) && (h_count < ha_end);
    assign in_vblank = ((v_count == va_end && h_count >= ha_end) || v_count > va_end) &&
                       ((v_count == va_sta && h_count <= ha_sta) || v_count < va_sta);

    // same wrap points as raster_counter
    assign line_end  = !(h_count < max_width);
    assign frame_end = line_end && !(v_count < max_height);

    // tracks the counter's line, so it flips on the same edge as v_count
    always_ff @(posedge clk_dvi) begin
        if (!rst)
            line_odd <= 1'b0;
        else if (frame_end)
            line_odd <= 1'b0;
        else if (line_end)
            line_odd <= ~line_odd;
    end

    // --------------------
    // output registers, one clock behind the counters
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hsync       <= ~hpolarity; // park at inactive level
            vsync       <= ~vpolarity;
            active      <= 1'b0;
            half_bright <= 1'b0;
        end else begin
            hsync       <= hpolarity ? hsync_ah : ~hsync_ah;
            vsync       <= vpolarity ? vsync_ah : ~vsync_ah;
            active      <= in_hwin && !in_vblank;
            half_bright <= line_odd; // dims every other doubled line
        end
    end

endmodule

// ==== hw/line_buffer_ram.sv ====
// Single-port raster line RAM
`timescale 1ns/10ps

module line_buffer_ram #(
    parameter int ADDR_W = 10, // enough for the widest native line
    parameter int DATA_W = 4
) (
    input  logic              clk_dvi,
    input  logic              we,
    input  logic              re,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] din,
    output logic [DATA_W-1:0] dout
);

    logic [DATA_W-1:0] mem [2**ADDR_W]; // maps to one block RAM

    always_ff @(posedge clk_dvi) begin
        if (we)
            mem[addr] <= din;
    end

    // registered read, holds while re is low
    always_ff @(posedge clk_dvi) begin
        if (re)
            dout <= mem[addr];
    end

endmodule

// ==== hw/line_buffer_pair.sv ====
// Ping-pong raster line buffers
`timescale 1ns/10ps

module line_buffer_pair (
    input  logic                    clk_dvi,
    input  logic                    rst,
    input  logic                    pixel_valid,
    input  dvi_sync_pkg::raster_x_t raster_x,
    input  dvi_sync_pkg::color_t    pixel_color,
    input  dvi_sync_pkg::hcount_t   h_count,
    input  dvi_sync_pkg::hcount_t   x_offset,
    output dvi_sync_pkg::color_t    pixel_out
);

    logic                    buf_sel;   // 0: write buf 0, read buf 1
    logic                    swap;      // first pixel of a new native line
    logic                    wr_sel;    // select including this cycle's swap
    logic                    rd_sel_q;  // select that matches dout
    dvi_sync_pkg::hcount_t   rd_sum;
    dvi_sync_pkg::raster_x_t rd_addr;
    dvi_sync_pkg::raster_x_t addr_0, addr_1;
    dvi_sync_pkg::color_t    dout_0, dout_1;

    // --------------------
    // buffer select, flips on pixel 0 so that pixel already lands in the new buffer
    assign swap   = pixel_valid && (raster_x == '0);
    assign wr_sel = buf_sel ^ swap;

    always_ff @(posedge clk_dvi) begin
        if (!rst)
            buf_sel <= 1'b0;
        else
            buf_sel <= wr_sel;
    end

    // each output column shown twice, so halve the shifted count
    assign rd_sum  = h_count + x_offset;
    assign rd_addr = dvi_sync_pkg::raster_x_t'(rd_sum >> 1);

    assign addr_0 = wr_sel ? rd_addr : raster_x;
    assign addr_1 = wr_sel ? raster_x : rd_addr;

    line_buffer_ram #(
        .ADDR_W ($bits(dvi_sync_pkg::raster_x_t)),
        .DATA_W ($bits(dvi_sync_pkg::color_t))
    ) line_buf_0 (
        .clk_dvi (clk_dvi),
        .we      (pixel_valid && !wr_sel),
        .re      (wr_sel),
        .addr    (addr_0),
        .din     (pixel_color),
        .dout    (dout_0)
    );

    line_buffer_ram #(
        .ADDR_W ($bits(dvi_sync_pkg::raster_x_t)),
        .DATA_W ($bits(dvi_sync_pkg::color_t))
    ) line_buf_1 (
        .clk_dvi (clk_dvi),
        .we      (pixel_valid && wr_sel),
        .re      (!wr_sel),
        .addr    (addr_1),
        .din     (pixel_color),
        .dout    (dout_1)
    );

    // --------------------
    // color register, second stage after the address
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            rd_sel_q  <= 1'b0;
            pixel_out <= '0;
        end else begin
            rd_sel_q  <= wr_sel;
            pixel_out <= rd_sel_q ? dout_0 : dout_1; // take the RAM not being written
        end
    end

endmodule

// ==== hw/dvi_sync_top.sv ====
// Line-doubling DVI sync generator
`timescale 1ns/10ps

module dvi_sync_top (
    input  logic                    clk_dvi,
    input  logic                    rst,
    input  dvi_sync_pkg::chip_t     chip,       // sampled during reset only
    input  logic                    hpolarity,
    input  logic                    vpolarity,
    input  logic                    pixel_valid,
    input  dvi_sync_pkg::raster_x_t raster_x,
    input  dvi_sync_pkg::raster_y_t raster_y,   // source line, for reference only
    input  dvi_sync_pkg::color_t    pixel_color,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    active,
    output logic                    half_bright,
    output dvi_sync_pkg::color_t    pixel_out
);

    // --------------------
    // timing set
    dvi_sync_pkg::hcount_t hs_sta, hs_end, ha_sta, ha_end, max_width, x_offset;
    dvi_sync_pkg::vcount_t vs_sta, vs_end, va_sta, va_end, max_height;
    dvi_sync_pkg::hcount_t h_count;
    dvi_sync_pkg::vcount_t v_count;

    chip_timing u_timing (
        .clk_dvi, .rst, .chip,
        .hs_sta, .hs_end, .ha_sta, .ha_end, .max_width, .x_offset,
        .vs_sta, .vs_end, .va_sta, .va_end, .max_height
    );

    // output position
    raster_counter u_counter (
        .clk_dvi, .rst, .max_width, .max_height,
        .h_count, .v_count
    );

    // --------------------
    // sync, one clock behind the counters
    sync_decoder u_sync (
        .clk_dvi, .rst, .hpolarity, .vpolarity,
        .h_count, .v_count,
        .hs_sta, .hs_end, .ha_sta, .ha_end, .max_width,
        .vs_sta, .vs_end, .va_sta, .va_end, .max_height,
        .hsync, .vsync, .active, .half_bright
    );

    // pixels, two clocks behind; raster_y goes nowhere, raster_x == 0 marks the line
    line_buffer_pair u_lines (
        .clk_dvi, .rst,
        .pixel_valid, .raster_x, .pixel_color,
        .h_count, .x_offset,
        .pixel_out
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_dvi,
    output logic rst,
    input  logic reset_req // one-cycle pulse restarts the reset sequence
);

    localparam int HALF_PERIOD = 4; // 8 ns period

    int rst_cnt; // edges spent in the current reset

    initial begin
        clk_dvi = 1'b0;
        rst     = 1'b0; // start in reset
        rst_cnt = 0;
    end

    always #HALF_PERIOD clk_dvi = ~clk_dvi;

    // low for 3 edges, then released
    always @(posedge clk_dvi) begin
        if (reset_req) begin
            rst_cnt <= 0;
            rst     <= 1'b0;
        end else if (rst_cnt < 3) begin
            rst_cnt <= rst_cnt + 1;
            rst     <= (rst_cnt == 2);
        end
    end

endmodule

// ==== tests/dvi_sync_assertions.sv ====
// DVI sync output assertions
`timescale 1ns/10ps
`include "dvi_sync_macros.svh"

module dvi_sync_assertions (
    input logic                 clk_dvi,
    input logic                 rst,
    input dvi_sync_pkg::chip_t  chip,      // sampled during reset, like the DUT
    input logic                 hpolarity,
    input logic                 vpolarity,
    input logic                 hsync,
    input logic                 vsync,
    input logic                 active,
    input logic                 half_bright,
    input dvi_sync_pkg::color_t pixel_out
);

    int   fail_count = 0; // read by the testbench
    logic hpol_q;         // polarity the current hsync was made with
    logic vpol_q;
    logic hs_ah;          // hsync as active high
    int   hs_len;         // cycles the current pulse has been high
    int   hs_width;       // expected pulse length for the latched chip

    // undoubled sync width straight from the timing table
    function automatic int table_sync_width(input dvi_sync_pkg::chip_t c);
        case (c)
            `CHIP_6567R8:   return `HS_END_NTSC8 - `HS_STA_NTSC8;
            `CHIP_6567R56A: return `HS_END_NTSC56 - `HS_STA_NTSC56;
            default:        return `HS_END_PAL - `HS_STA_PAL; // both 6569 codes
        endcase
    endfunction

    assign hs_ah = hpol_q ? hsync : ~hsync;

    always_ff @(posedge clk_dvi) begin
        hpol_q <= hpolarity;
        vpol_q <= vpolarity;
        if (!rst)
            hs_width <= 2 * table_sync_width(chip); // x is doubled
        if (!rst)
            hs_len <= 0;
        else if (hs_ah)
            hs_len <= hs_len + 1;
        else
            hs_len <= 0;
    end

    // --------------------
    // everything parked one edge after reset
    reset_idle: assert property (@(posedge clk_dvi)
        !rst |=> (!active && !half_bright && pixel_out == '0 &&
                  hsync == ~hpol_q && vsync == ~vpol_q))
        else begin
            $error("outputs not idle after a reset edge");
            fail_count++;
        end

    // sync pulse sits in the blank
    sync_not_active: assert property (@(posedge clk_dvi) disable iff (!rst)
        !(hs_ah && active))
        else begin
            $error("hsync and active high together");
            fail_count++;
        end

    // doubled sync width
    sync_width: assert property (@(posedge clk_dvi) disable iff (!rst)
        $fell(hs_ah) |-> hs_len == hs_width)
        else begin
            $error("hsync pulse lasted %0d cycles instead of %0d", hs_len, hs_width);
            fail_count++;
        end

endmodule

bind dvi_sync_top dvi_sync_assertions u_assertions (
    .clk_dvi     (clk_dvi),
    .rst         (rst),
    .chip        (chip),
    .hpolarity   (hpolarity),
    .vpolarity   (vpolarity),
    .hsync       (hsync),
    .vsync       (vsync),
    .active      (active),
    .half_bright (half_bright),
    .pixel_out   (pixel_out)
);

// ==== tests/tb_dvi_sync.sv ====
// DVI sync generator testbench
`timescale 1ns/10ps
`include "dvi_sync_macros.svh"

module tb_dvi_sync;

    localparam int PIX_PER_LINE = 520;
    localparam int NUM_TESTS    = 5;
    localparam int PIX_TEST     = 4;       // pixel check index
    localparam int FRAME_LIMIT  = 1200000; // cycles allowed per frame wait
    localparam int MAX_PRINTS   = 20;      // FAIL lines per test
    // timing table selectors
    localparam int T_HS_STA = 0, T_HS_END = 1, T_HA_STA = 2, T_HA_END = 3;
    localparam int T_VS_STA = 4, T_VS_END = 5, T_VA_STA = 6, T_VA_END = 7;
    localparam int T_MAX_W  = 8, T_MAX_H  = 9;

    logic clk_dvi, rst, reset_req;
    dvi_sync_pkg::chip_t       chip;
    logic                      hpolarity, vpolarity, pixel_valid;
    dvi_sync_pkg::raster_x_t   raster_x;
    dvi_sync_pkg::raster_y_t   raster_y;
    dvi_sync_pkg::color_t      pixel_color, pixel_out;
    logic                      hsync, vsync, active, half_bright;

    // model state, updated on posedge, compared on negedge
    int m_h, m_v, m_odd, m_chip, frames;
    logic [3:0] exp_ctl;       // hsync, vsync, active, half_bright
    logic in_reset, started;
    int swaps, since_swap;
    dvi_sync_pkg::color_t cur_color, done_color;
    // stimulus state
    int line_cyc, line_num, stim_len;
    int unsigned lcg_state = 49;
    // bookkeeping
    int errs [NUM_TESTS];
    int checks [NUM_TESTS];
    string names [NUM_TESTS];
    int test_idx;
    logic timed_out;

    tb_clock_gen u_clk (.clk_dvi(clk_dvi), .rst(rst), .reset_req(reset_req));

    dvi_sync_top DUT (
        .clk_dvi, .rst, .chip, .hpolarity, .vpolarity,
        .pixel_valid, .raster_x, .raster_y, .pixel_color,
        .hsync, .vsync, .active, .half_bright, .pixel_out
    );

    // --------------------
    // helpers
    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // undoubled table value for a chip code
    function automatic int tval(input int chip_code, input int sel);
        int set; // 0 ntsc8, 1 ntsc56, 2 pal
        set = (chip_code == `CHIP_6567R8) ? 0 : (chip_code == `CHIP_6567R56A) ? 1 : 2;
        case (sel)
            T_HS_STA: return set == 0 ? `HS_STA_NTSC8 : set == 1 ? `HS_STA_NTSC56 : `HS_STA_PAL;
            T_HS_END: return set == 0 ? `HS_END_NTSC8 : set == 1 ? `HS_END_NTSC56 : `HS_END_PAL;
            T_HA_STA: return set == 0 ? `HA_STA_NTSC8 : set == 1 ? `HA_STA_NTSC56 : `HA_STA_PAL;
            T_HA_END: return set == 0 ? `HA_END_NTSC8 : set == 1 ? `HA_END_NTSC56 : `HA_END_PAL;
            T_VS_STA: return set == 0 ? `VS_STA_NTSC8 : set == 1 ? `VS_STA_NTSC56 : `VS_STA_PAL;
            T_VS_END: return set == 0 ? `VS_END_NTSC8 : set == 1 ? `VS_END_NTSC56 : `VS_END_PAL;
            T_VA_STA: return set == 0 ? `VA_STA_NTSC8 : set == 1 ? `VA_STA_NTSC56 : `VA_STA_PAL;
            T_VA_END: return set == 0 ? `VA_END_NTSC8 : set == 1 ? `VA_END_NTSC56 : `VA_END_PAL;
            T_MAX_W:  return set == 0 ? `MAX_W_NTSC8  : set == 1 ? `MAX_W_NTSC56  : `MAX_W_PAL;
            default:  return set == 0 ? `MAX_H_NTSC8  : set == 1 ? `MAX_H_NTSC56  : `MAX_H_PAL;
        endcase
    endfunction

    // expected {hsync, vsync, active, half_bright} for a position
    function automatic logic [3:0] ref_outputs(input int h, input int v, input int odd,
                                               input int chip_code, input logic hpol,
                                               input logic vpol);
        int hss, hse, has, hae, vss, vse, vas, vae;
        logic hs, vs, blank, act;
        hss = 2 * tval(chip_code, T_HS_STA);
        hse = 2 * tval(chip_code, T_HS_END);
        has = 2 * tval(chip_code, T_HA_STA);
        hae = 2 * tval(chip_code, T_HA_END);
        vss = 2 * tval(chip_code, T_VS_STA);
        vse = 2 * tval(chip_code, T_VS_END);
        vas = 2 * tval(chip_code, T_VA_STA);
        vae = 2 * tval(chip_code, T_VA_END);
        hs = (h >= hss) && (h < hse);
        vs = ((v == vss && h >= hss) || v > vss) && ((v == vse && h < hse) || v < vse);
        blank = ((v == vae && h >= hae) || v > vae) && ((v == vas && h <= has) || v < vas);
        act = (h > has) && (h < hae) && !blank;
        return {hpol ? hs : ~hs, vpol ? vs : ~vs, act, odd[0]};
    endfunction

    task automatic report_value(input int idx, input string what, input int exp_v,
                                input int act_v);
        errs[idx]++;
        if (errs[idx] <= MAX_PRINTS)
            $display("FAIL %s %s: expected %0h, actual %0h at %0t",
                     names[idx], what, exp_v, act_v, $time);
    endtask

    // --------------------
    // reference model, follows the counter rules on every edge
    always @(posedge clk_dvi) begin
        started = 1'b1;
        if (!rst) begin
            m_chip     = chip; // latched only in reset
            m_h        = 0;
            m_v        = 0;
            m_odd      = 0;
            exp_ctl    = {~hpolarity, ~vpolarity, 2'b00};
            in_reset   = 1'b1;
            swaps      = 0;
            since_swap = 0;
        end else begin
            in_reset = 1'b0;
            exp_ctl  = ref_outputs(m_h, m_v, m_odd, m_chip, hpolarity, vpolarity);
            if (m_h >= tval(m_chip, T_MAX_W)) begin
                m_h = 0;
                if (m_v >= tval(m_chip, T_MAX_H)) begin
                    m_v   = 0; // frame wrap clears the odd flag
                    m_odd = 0;
                    frames++;
                end else begin
                    m_v++;
                    m_odd = 1 - m_odd;
                end
            end else begin
                m_h++;
            end
            // line swap tracking
            if (pixel_valid && raster_x == '0) begin
                swaps++;
                since_swap = 0;
                done_color = cur_color;
                cur_color  = pixel_color;
            end else begin
                since_swap++;
            end
        end
    end

    // compare on the falling edge where everything is settled
    always @(negedge clk_dvi) begin
        if (started) begin
            checks[test_idx]++;
            if ({hsync, vsync, active, half_bright} !== exp_ctl)
                report_value(test_idx, "sync", exp_ctl, {hsync, vsync, active, half_bright});
            if (in_reset && pixel_out !== '0)
                report_value(test_idx, "pixel_out", 0, pixel_out);
            if (!in_reset && swaps >= 2 && since_swap >= 2) begin // third edge on
                checks[PIX_TEST]++;
                if (pixel_out !== done_color)
                    report_value(PIX_TEST, "pixel_out", done_color, pixel_out);
            end
        end
    end

    // --------------------
    // pixel source, one pixel every 3 cycles, line pace twice the output line
    always @(posedge clk_dvi) begin
        if (!rst) begin
            pixel_valid <= 1'b0;
            line_cyc    <= 0;
            line_num    <= 0;
            stim_len    <= 2 * (tval(chip, T_MAX_W) + 1);
        end else begin
            if (line_cyc % 3 == 0 && line_cyc / 3 < PIX_PER_LINE) begin
                if (line_cyc == 0) begin
                    lcg_state = lcg_next(lcg_state); // new color per line
                    pixel_color <= dvi_sync_pkg::color_t'(lcg_state >> 16);
                    raster_y    <= dvi_sync_pkg::raster_y_t'(line_num);
                end
                pixel_valid <= 1'b1;
                raster_x    <= dvi_sync_pkg::raster_x_t'(line_cyc / 3);
            end else begin
                pixel_valid <= 1'b0;
            end
            if (line_cyc + 1 >= stim_len) begin
                line_cyc <= 0;
                line_num <= line_num + 1;
            end else begin
                line_cyc <= line_cyc + 1;
            end
        end
    end

    // --------------------
    // sequencing
    task automatic wait_reset_release(output logic ok);
        int n;
        n = 0;
        do begin
            @(negedge clk_dvi);
            n++;
        end while (!rst && n < 50);
        ok = rst;
        if (!ok)
            $display("timeout: reset never released");
    endtask

    task automatic wait_frames(input int count, output logic ok);
        int n, target;
        n = 0;
        target = frames + count;
        while (frames < target && n < count * FRAME_LIMIT) begin
            @(negedge clk_dvi);
            n++;
        end
        ok = (frames >= target);
        if (!ok)
            $display("timeout: frame counter stopped advancing in %s", names[test_idx]);
    endtask

    task automatic restart_with(input int idx, input int chip_code, input logic hpol,
                                input logic vpol);
        @(posedge clk_dvi);
        test_idx  = idx;
        chip      <= dvi_sync_pkg::chip_t'(chip_code);
        hpolarity <= hpol;
        vpolarity <= vpol;
        reset_req <= 1'b1;
        @(posedge clk_dvi);
        reset_req <= 1'b0;
    endtask

    task automatic finish_test(input int idx);
        $display("%s: %0d checks, %0d errors", names[idx], checks[idx], errs[idx]);
    endtask

    task automatic run_tests();
        logic ok;
        // 1: reset and the first output at (0,0)
        wait_reset_release(ok);
        if (!ok) begin
            timed_out = 1'b1;
            return;
        end
        @(posedge clk_dvi);
        @(posedge clk_dvi);
        finish_test(0);
        // 2: one ntsc frame, both polarities high
        test_idx = 1;
        wait_frames(1, ok);
        finish_test(1);
        if (!ok) begin
            timed_out = 1'b1;
            return;
        end
        // 3: pal with inverted hsync
        restart_with(2, `CHIP_6569R3, 1'b0, 1'b1);
        wait_reset_release(ok);
        if (ok)
            wait_frames(1, ok);
        finish_test(2);
        if (!ok) begin
            timed_out = 1'b1;
            return;
        end
        // 4: two frames across the wrap
        restart_with(3, `CHIP_6567R56A, 1'b1, 1'b1);
        wait_reset_release(ok);
        if (ok)
            wait_frames(2, ok);
        finish_test(3);
        if (!ok)
            timed_out = 1'b1;
    endtask

    initial begin
        int total_err, total_chk;
        names[0] = "reset_idle";
        names[1] = "ntsc8_frame";
        names[2] = "pal_frame";
        names[3] = "ntsc56_two_frames";
        names[4] = "pixel_doubling";
        for (int i = 0; i < NUM_TESTS; i++) begin
            errs[i]   = 0;
            checks[i] = 0;
        end
        test_idx    = 0;
        timed_out   = 1'b0;
        started     = 1'b0;
        frames      = 0;
        reset_req   = 1'b0;
        chip        = dvi_sync_pkg::chip_t'(`CHIP_6567R8);
        hpolarity   = 1'b1;
        vpolarity   = 1'b1;
        pixel_valid = 1'b0;
        raster_x    = '0;
        raster_y    = '0;
        pixel_color = '0;

        run_tests();

        finish_test(PIX_TEST);
        if (checks[PIX_TEST] == 0) begin
            $display("pixel_doubling never reached a checked line");
            errs[PIX_TEST]++;
        end
        total_err = DUT.u_assertions.fail_count;
        total_chk = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total_err += errs[i];
            total_chk += checks[i];
        end
        $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 NUM_TESTS, total_chk, total_err, DUT.u_assertions.fail_count);
        if (timed_out || total_err != 0)
            $display("TEST FAILED");
        else
            $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/dvi_sync_pkg.sv
hw/chip_timing.sv
hw/raster_counter.sv
hw/sync_decoder.sv
hw/line_buffer_ram.sv
hw/line_buffer_pair.sv
hw/dvi_sync_top.sv
tests/tb_clock_gen.sv
tests/dvi_sync_assertions.sv
tests/tb_dvi_sync.sv

// ==== Bender.yml ====
package:
  name: dvi_sync

sources:
  - include_dirs:
      - hw
    files:
      - hw/dvi_sync_pkg.sv
      - hw/chip_timing.sv
      - hw/raster_counter.sv
      - hw/sync_decoder.sv
      - hw/line_buffer_ram.sv
      - hw/line_buffer_pair.sv
      - hw/dvi_sync_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_clock_gen.sv
      - tests/dvi_sync_assertions.sv
      - tests/tb_dvi_sync.sv
